// ==== build.f ====
source/mem_pkg.sv
source/mem_if.sv
source/store_align.sv
source/dual_port_ram.sv
source/load_align.sv
source/mem_subsystem.sv
testbench/mem_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timescale 1ns/1ps --top-module mem_subsystem_tb \
    -f build.f -o mem_subsystem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mem_subsystem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== testbench/mem_subsystem_tb.sv ====
`default_nettype none

module mem_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    typedef enum int {k_store, k_load, k_fetch, k_load_store, k_hold} kind_t;

    logic                   clk;
    logic                   reset;
    logic [addr_width-1:0]  pc;
    logic [addr_width-1:0]  addr;
    width_op_t              width;
    logic [xlen-1:0]        store_data;
    logic                   store_en;
    logic                   load_en;
    logic [xlen-1:0]        load_data;
    logic                   load_valid;
    logic [inst_width-1:0]  inst;

    // stimulus table with one entry per test.
    string                  test_name[$];
    kind_t                  test_kind[$];
    width_op_t              test_width[$];
    logic [addr_width-1:0]  test_addr[$];
    logic [xlen-1:0]        test_data[$];
    bit                     test_rand[$];

    // byte-wide model of the RAM contents.
    logic [7:0]             shadow [2**addr_width];
    logic [xlen-1:0]        last_load;
    logic [31:0]            lfsr;
    int                     errors;
    int                     passed;
    int                     failed;
    int                     cycles;
    int                     limit;

    mem_subsystem uut (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .addr       (addr),
        .width      (width),
        .store_data (store_data),
        .store_en   (store_en),
        .load_en    (load_en),
        .load_data  (load_data),
        .load_valid (load_valid),
        .inst       (inst)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_word(output logic [xlen-1:0] value);
        value = '0;
        for (int i = 0; i < xlen; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[xlen-2:0], lfsr[0]};
        end
    endtask

    function automatic int width_bytes(input width_op_t w);
        case (w)
            w8:      return 1;
            w16:     return 2;
            w32:     return 4;
            default: return 8;
        endcase
    endfunction

    // zero-extended little endian read.
    function automatic logic [xlen-1:0] shadow_read(input logic [addr_width-1:0] a, input int n);
        logic [xlen-1:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = value | (xlen'(shadow[addr_width'(a + i)]) << (8 * i));
        end
        return value;
    endfunction

    // lanes past the end of the doubleword are dropped.
    task automatic shadow_write(input width_op_t w, input logic [addr_width-1:0] a,
                                input logic [xlen-1:0] d);
        for (int i = 0; i < width_bytes(w); i++) begin
            if (int'(a[2:0]) + i < lane_count) begin
                shadow[addr_width'(a + i)] = 8'(d >> (8 * i));
            end
        end
    endtask

    task automatic check_data(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: load_data expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_inst(input string name, input logic [inst_width-1:0] expected,
                              input logic [inst_width-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: inst expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: load_valid expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic add_test(input string name, input kind_t kind, input width_op_t w,
                            input logic [addr_width-1:0] a, input logic [xlen-1:0] d,
                            input bit use_rand);
        test_name.push_back(name);
        test_kind.push_back(kind);
        test_width.push_back(w);
        test_addr.push_back(a);
        test_data.push_back(d);
        test_rand.push_back(use_rand);
    endtask

    // store then load at every aligned offset of one doubleword.
    task automatic add_round_trip(input string tag, input width_op_t w,
                                  input logic [addr_width-1:0] base);
        for (int off = 0; off < lane_count; off += width_bytes(w)) begin
            add_test($sformatf("%s_%0d_st", tag, off), k_store, w,
                     addr_width'(base + off), '0, 1'b1);
            add_test($sformatf("%s_%0d_ld", tag, off), k_load, w,
                     addr_width'(base + off), '0, 1'b0);
        end
    endtask

    task automatic build_table();
        add_round_trip("rt_b", w8, 12'h100);
        add_round_trip("rt_h", w16, 12'h108);
        add_round_trip("rt_w", w32, 12'h110);
        add_round_trip("rt_d", w64, 12'h118);
        add_test("part_fill", k_store, w64, 12'h200, '0, 1'b1);
        add_test("part_b3", k_store, w8, 12'h203, 64'hdead_beef_cafe_125a, 1'b0);
        add_test("part_h6", k_store, w16, 12'h206, 64'h1234_5678_9abc_beef, 1'b0);
        add_test("part_b0", k_store, w8, 12'h200, 64'h0f0f_0f0f_0f0f_0fc3, 1'b0);
        add_test("part_check", k_load, w64, 12'h200, '0, 1'b0);
        add_test("fetch_st_lo", k_store, w32, 12'h300, 64'hffff_ffff_0050_0513, 1'b0);
        add_test("fetch_st_hi", k_store, w32, 12'h304, 64'heeee_eeee_00a5_8593, 1'b0);
        add_test("fetch_lo", k_fetch, w32, 12'h300, '0, 1'b0);
        add_test("fetch_hi", k_fetch, w32, 12'h304, '0, 1'b0);
        add_test("rdw_fill", k_store, w64, 12'h400, '0, 1'b1);
        add_test("rdw_same", k_load_store, w64, 12'h400, 64'h0123_4567_89ab_cdef, 1'b0);
        add_test("rdw_after", k_load, w64, 12'h400, '0, 1'b0);
        add_test("hold_load", k_load, w16, 12'h402, '0, 1'b0);
        add_test("hold_idle", k_hold, w64, 12'h400, '0, 1'b1);
        add_test("hold_after", k_load, w64, 12'h400, '0, 1'b0);
    endtask

    task automatic apply_store(input string name, input width_op_t w,
                               input logic [addr_width-1:0] a, input logic [xlen-1:0] d);
        addr = a;
        width = w;
        store_data = d;
        store_en = 1'b1;
        @(negedge clk);
        store_en = 1'b0;
        shadow_write(w, a, d);
        check_bit(name, 1'b0, load_valid);
    endtask

    // a load may share its edge with a store to the same word.
    task automatic apply_load(input string name, input width_op_t w,
                              input logic [addr_width-1:0] a, input bit with_store,
                              input logic [xlen-1:0] d);
        logic [xlen-1:0] expected;
        expected = shadow_read(a, width_bytes(w));
        addr = a;
        width = w;
        store_data = d;
        store_en = with_store;
        load_en = 1'b1;
        @(negedge clk);
        store_en = 1'b0;
        load_en = 1'b0;
        if (with_store) begin
            shadow_write(w, a, d);
        end
        if (load_valid !== 1'b1) begin
            $display("%s: load_valid did not rise one cycle after the load", name);
            errors++;
        end else begin
            check_data(name, expected, load_data);
        end
        last_load = expected;
        @(negedge clk);
        check_bit(name, 1'b0, load_valid);
    endtask

    task automatic apply_fetch(input string name, input logic [addr_width-1:0] a);
        pc = a;
        @(negedge clk);
        check_inst(name, inst_width'(shadow_read({a[addr_width-1:2], 2'b00}, 4)), inst);
    endtask

    // one idle cycle and then two stores into the word last loaded.
    task automatic apply_hold(input string name, input width_op_t w,
                              input logic [addr_width-1:0] a, input logic [xlen-1:0] d);
        for (int c = 0; c < 3; c++) begin
            addr = a;
            width = w;
            store_data = (c == 1) ? d : ~d;
            store_en = (c > 0);
            @(negedge clk);
            if (c > 0) begin
                shadow_write(w, a, store_data);
            end
            check_bit(name, 1'b0, load_valid);
            check_data(name, last_load, load_data);
        end
        store_en = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%-14s ok", name);
            passed++;
        end else begin
            $display("%-14s failed", name);
            failed++;
        end
    endtask

    initial begin
        logic [xlen-1:0] data;
        int errors_before;
        clk = 1'b0;
        reset = 1'b1;
        pc = '0;
        addr = '0;
        width = w8;
        store_data = '0;
        store_en = 1'b0;
        load_en = 1'b0;
        lfsr = 32'h02ff4f0d;
        errors = 0;
        passed = 0;
        failed = 0;
        cycles = 0;
        last_load = '0;
        build_table();
        limit = 4 * (test_name.size() + 1) + 8 + 20;

        // outputs stay at zero through reset and until the first load.
        repeat (8) begin
            @(negedge clk);
            check_bit("reset_state", 1'b0, load_valid);
            check_data("reset_state", '0, load_data);
            check_inst("reset_state", '0, inst);
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_bit("reset_state", 1'b0, load_valid);
            check_data("reset_state", '0, load_data);
        end
        report_test("reset_state", 0);

        for (int t = 0; t < test_name.size(); t++) begin
            errors_before = errors;
            if (test_rand[t]) begin
                random_word(data);
            end else begin
                data = test_data[t];
            end
            case (test_kind[t])
                k_store:      apply_store(test_name[t], test_width[t], test_addr[t], data);
                k_load:       apply_load(test_name[t], test_width[t], test_addr[t], 1'b0, data);
                k_load_store: apply_load(test_name[t], test_width[t], test_addr[t], 1'b1, data);
                k_fetch:      apply_fetch(test_name[t], test_addr[t]);
                default:      apply_hold(test_name[t], test_width[t], test_addr[t], data);
            endcase
            report_test(test_name[t], errors_before);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [mem_pkg::addr_width-1:0] pc,
    input  logic [mem_pkg::addr_width-1:0] addr,
    input  mem_pkg::width_op_t             width,
    input  logic [mem_pkg::xlen-1:0]       store_data,
    input  logic                           store_en,
    input  logic                           load_en,
    output logic [mem_pkg::xlen-1:0]       load_data,
    output logic                           load_valid,
    output logic [mem_pkg::inst_width-1:0] inst
);
    import mem_pkg::*;

    localparam int offset_width = $clog2(lane_count);

    logic [index_width-1:0] pc_index;
    logic [xlen-1:0]        rdata;
    logic [xlen-1:0]        iword;

    data_req_if req_bus ();
    lane_ctx_if ctx_bus ();

    // fetch word index, pc bits below 2 pick nothing inside a 32-bit instruction.
    assign pc_index = pc[addr_width-1:offset_width];

    // context the output side needs once the RAM answers.
    assign ctx_bus.offset  = addr[offset_width-1:0];
    assign ctx_bus.width   = width;
    assign ctx_bus.ren     = load_en;
    assign ctx_bus.pc_half = pc[2];

    // input side.
    store_align u_store_align (
        .addr       (addr),
        .width      (width),
        .store_data (store_data),
        .store_en   (store_en),
        .load_en    (load_en),
        .req        (req_bus)
    );

    dual_port_ram u_ram (
        .clk      (clk),
        .req      (req_bus),
        .pc_index (pc_index),
        .rdata    (rdata),
        .iword    (iword)
    );

    // output side, lined up with the RAM read latency.
    load_align u_load_align (
        .clk        (clk),
        .reset      (reset),
        .ctx        (ctx_bus),
        .rdata      (rdata),
        .iword      (iword),
        .load_data  (load_data),
        .load_valid (load_valid),
        .inst       (inst)
    );

endmodule

`default_nettype wire

// ==== source/load_align.sv ====
`default_nettype none

module load_align (
    input  logic                           clk,
    input  logic                           reset,
    lane_ctx_if.sink                       ctx,
    input  logic [mem_pkg::xlen-1:0]       rdata,
    input  logic [mem_pkg::xlen-1:0]       iword,
    output logic [mem_pkg::xlen-1:0]       load_data,
    output logic                           load_valid,
    output logic [mem_pkg::inst_width-1:0] inst
);
    import mem_pkg::*;

    localparam int offset_width = $clog2(lane_count);

    logic [offset_width-1:0] offset_q;
    width_op_t               width_q;
    logic                    pc_half_q;
    logic                    load_seen;
    logic                    fetch_seen;
    logic [7:0]              byte_slice;
    logic [15:0]             half_slice;
    logic [31:0]             word_slice;
    logic [xlen-1:0]         load_ext;

    // control state.
    // load_seen and fetch_seen keep the outputs at zero until the RAM has answered once.
    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid <= 1'b0;
            load_seen  <= 1'b0;
            fetch_seen <= 1'b0;
        end else begin
            load_valid <= ctx.ren;
            fetch_seen <= 1'b1;
            if (ctx.ren) begin
                load_seen <= 1'b1;
            end
        end
    end

    // lane context, captured at the same edge the RAM reads.
    // offset and width only move with a load so they stay matched to the held rdata.
    always_ff @(posedge clk) begin
        pc_half_q <= ctx.pc_half;
        if (ctx.ren) begin
            offset_q <= ctx.offset;
            width_q  <= ctx.width;
        end
    end

    // candidate slices, halves and words use the aligned position below the offset.
    assign byte_slice = rdata[{offset_q, 3'b000} +: 8];
    assign half_slice = rdata[{offset_q[offset_width-1:1], 4'b0000} +: 16];
    assign word_slice = rdata[{offset_q[offset_width-1], 5'b00000} +: 32];

    // zero-extend the slice picked by the width.
    always_comb begin
        case (width_q)
            w8: begin
                load_ext = {{(xlen-8){1'b0}}, byte_slice};
            end
            w16: begin
                load_ext = {{(xlen-16){1'b0}}, half_slice};
            end
            w32: begin
                load_ext = {{(xlen-32){1'b0}}, word_slice};
            end
            default: begin
                load_ext = rdata;
            end
        endcase
    end

    // the held value lives in the RAM read register; this only picks lanes from it.
    assign load_data = load_seen ? load_ext : '0;

    // instruction half chosen by pc bit 2.
    assign inst = !fetch_seen ? '0 :
                  pc_half_q   ? iword[xlen-1:inst_width] :
                                iword[inst_width-1:0];

endmodule

`default_nettype wire

// ==== source/dual_port_ram.sv ====
`default_nettype none

module dual_port_ram (
    input  logic                            clk,
    data_req_if.sink                        req,
    input  logic [mem_pkg::index_width-1:0] pc_index,
    output logic [mem_pkg::xlen-1:0]        rdata,
    output logic [mem_pkg::xlen-1:0]        iword
);
    import mem_pkg::*;

    // doubleword storage.
    logic [xlen-1:0] mem [mem_words];

    // data port write, only the enabled byte lanes change.
    always_ff @(posedge clk) begin
        if (req.wen) begin
            for (int lane = 0; lane < lane_count; lane++) begin
                if (req.byte_en[lane]) begin
                    mem[req.index][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // data port read.
    // rdata holds between loads, so the load result stays stable.
    // a write to the same word at the same edge is not seen here, the old word comes out.
    always_ff @(posedge clk) begin
        if (req.ren) begin
            rdata <= mem[req.index];
        end
    end

    // instruction port, a fetch every cycle.
    always_ff @(posedge clk) begin
        iword <= mem[pc_index];
    end

endmodule

`default_nettype wire

// ==== source/store_align.sv ====
`default_nettype none

module store_align (
    input  logic [mem_pkg::addr_width-1:0] addr,
    input  mem_pkg::width_op_t             width,
    input  logic [mem_pkg::xlen-1:0]       store_data,
    input  logic                           store_en,
    input  logic                           load_en,
    data_req_if.source                     req
);
    import mem_pkg::*;

    localparam int offset_width = $clog2(lane_count);

    logic [offset_width-1:0] offset;
    logic [lane_count-1:0]   base_mask;
    logic [2*lane_count-1:0] mask_wide;
    logic [2*xlen-1:0]       data_wide;

    // byte offset inside the doubleword.
    assign offset = addr[offset_width-1:0];

    // lanes touched by an access at offset zero.
    always_comb begin
        case (width)
            w8: begin
                base_mask = 8'h01;
            end
            w16: begin
                base_mask = 8'h03;
            end
            w32: begin
                base_mask = 8'h0f;
            end
            default: begin
                base_mask = 8'hff;
            end
        endcase
    end

    // move mask and data up to the addressed lane.
    // anything pushed past lane 7 falls off, there is no wrap into the next word.
    always_comb begin
        mask_wide = {{lane_count{1'b0}}, base_mask} << offset;
        data_wide = {{xlen{1'b0}}, store_data} << {offset, 3'b000};
    end

    assign req.byte_en = mask_wide[lane_count-1:0];
    assign req.wdata   = data_wide[xlen-1:0];

    // word index from the upper address bits.
    assign req.index = addr[addr_width-1:offset_width];

    // strobes go straight through, the RAM samples them at the edge.
    assign req.wen = store_en;
    assign req.ren = load_en;

endmodule

`default_nettype wire

// ==== source/mem_if.sv ====
`default_nettype none

// data-port request, from the store aligner into the RAM.
interface data_req_if;
    import mem_pkg::*;

    logic [index_width-1:0] index;
    logic [lane_count-1:0]  byte_en;
    logic [xlen-1:0]        wdata;
    logic                   wen;
    logic                   ren;

    modport source (
        output index,
        output byte_en,
        output wdata,
        output wen,
        output ren
    );

    modport sink (
        input index,
        input byte_en,
        input wdata,
        input wen,
        input ren
    );

endinterface

// lane context of a load and a fetch, needed again when the RAM answers.
interface lane_ctx_if;
    import mem_pkg::*;

    logic [$clog2(lane_count)-1:0] offset;
    width_op_t                     width;
    logic                          ren;
    logic                          pc_half;

    modport sink (
        input offset,
        input width,
        input ren,
        input pc_half
    );

endinterface

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // data width of the core, also the width of one RAM word.
    localparam int xlen = 64;

    // instruction width.
    localparam int inst_width = 32;

    // byte lanes in one doubleword.
    localparam int lane_count = xlen / 8;

    // RAM depth in doublewords.
    localparam int mem_words = 512;

    // word index into the RAM.
    localparam int index_width = $clog2(mem_words);

    // byte address seen at the top level: word index plus lane offset.
    localparam int addr_width = index_width + $clog2(lane_count);

    // access width of a load or store.
    // the encoding follows the width field of the decoder.
    typedef enum logic [1:0] {
        w8  = 2'b00,
        w16 = 2'b01,
        w32 = 2'b10,
        w64 = 2'b11
    } width_op_t;

endpackage

`default_nettype wire
